//--- Makefile
# Verilator build and run of the float/int conversion testbench

SIM  := obj_dir/Vtb_fp_cast
SRCS := $(shell grep '\.sv$$' files.f)

.PHONY: all run clean

all: run

# Rebuilt only when a source, the header or the file list changes
$(SIM): files.f $(SRCS) tests/tb_fp_cast_ref.svh
	verilator --binary --timing -j 0 --top-module tb_fp_cast -Mdir obj_dir -f files.f

run: $(SIM)
	$(SIM) > sim.log 2>&1; cat sim.log
	@if grep -q "TB FAILED" sim.log; then exit 1; fi
	@grep -q "TB PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

//--- files.f
+incdir+tests
logic/cast_pkg.sv
logic/cast_pipe_stage.sv
logic/f2i_align.sv
logic/i2f_normalize.sv
logic/cast_round.sv
logic/fp_cast_top.sv
tests/tb_fp_cast.sv

//--- tests/tb_fp_cast_ref.svh
// ----------------------------------------------------------
// Reference model of the binary32 <-> int32 conversions
// Integer arithmetic only, plus the test vector list
// ----------------------------------------------------------
`ifndef TB_FP_CAST_REF_SVH
`define TB_FP_CAST_REF_SVH

typedef struct {
  logic [31:0] operand;
  cast_op_e    op;
  logic        uns;   // Unsigned integer side
  round_mode_e rm;
  string       name;
} vec_t;

vec_t vecs[$];  // Every request of the run, in order

// Round-up decision from the kept LSB and the dropped remainder
function automatic logic round_inc(round_mode_e rm, logic neg, logic lsb,
                                   longint unsigned rem, longint unsigned half);
  logic up;
  case (rm)
    RNE:     up = (rem != 0) && ((rem > half) || (rem == half && lsb));  // Tie goes to even
    RTZ:     up = 1'b0;
    RDN:     up = (rem != 0) && neg;
    default: up = (rem != 0) && !neg;  // RUP
  endcase
  return up;
endfunction

function automatic void ref_cast(input vec_t v, output logic [31:0] res,
                                 output cast_status_t st);
  logic            neg;
  longint unsigned mag;
  longint unsigned kept;
  longint unsigned rem;
  longint unsigned half;
  int              msb;
  int              exp;
  int              sh;
  st   = '0;
  res  = '0;
  rem  = 64'd0;
  half = 64'd0;
  if (v.op == I2F) begin
    neg = !v.uns && v.operand[31];
    mag = neg ? (64'h1_0000_0000 - 64'(v.operand)) : 64'(v.operand);
    if (mag == 0) return;  // +0, exact
    msb = 0;
    for (int i = 0; i < 32; i++) begin
      if (mag[i]) msb = i;
    end
    exp  = 127 + msb;
    sh   = (msb > 23) ? msb - 23 : 0;
    kept = (msb > 23) ? mag >> sh : mag << (23 - msb);  // 24 significant bits
    rem  = mag & ((64'd1 << sh) - 1);
    half = (sh > 0) ? (64'd1 << (sh - 1)) : 64'd0;
    if (round_inc(v.rm, neg, kept[0], rem, half)) begin
      kept = kept + 1;
    end
    if (kept == (64'd1 << 24)) begin  // Mantissa carry into the exponent
      kept = kept >> 1;
      exp  = exp + 1;
    end
    res   = {neg, 8'(exp), kept[22:0]};
    st.nx = (rem != 0);
  end else begin
    neg = v.operand[31];
    exp = int'(v.operand[30:23]);
    mag = {40'd0, |v.operand[30:23], v.operand[22:0]};
    if (exp == 255) begin
      st.nv = 1'b1;
      if (v.operand[22:0] != 0 || !neg) begin
        res = v.uns ? 32'hffff_ffff : 32'h7fff_ffff;  // NaN or +inf
      end else begin
        res = v.uns ? 32'h0 : 32'h8000_0000;
      end
      return;
    end
    if (exp == 0) exp = 1;  // Subnormal scale
    sh = 150 - exp;         // Value is mag * 2^-sh
    if (sh < -16) begin
      kept = 64'd1 << 40;   // Far beyond any int32
    end else if (sh <= 0) begin
      kept = mag << -sh;
    end else begin
      if (sh > 40) sh = 40; // Only sticky left beyond this
      kept = mag >> sh;
      rem  = mag & ((64'd1 << sh) - 1);
      half = 64'd1 << (sh - 1);
      if (round_inc(v.rm, neg, kept[0], rem, half)) begin
        kept = kept + 1;
      end
    end
    if (v.uns) begin
      st.nv = neg ? (kept != 0) : (kept > 64'hffff_ffff);
      res   = (neg || st.nv) ? (neg ? 32'h0 : 32'hffff_ffff) : kept[31:0];
    end else if (neg) begin
      st.nv = (kept > 64'h8000_0000);
      res   = st.nv ? 32'h8000_0000 : -kept[31:0];
    end else begin
      st.nv = (kept > 64'h7fff_ffff);
      res   = st.nv ? 32'h7fff_ffff : kept[31:0];
    end
    st.nx = !st.nv && (rem != 0);
  end
endfunction

`endif

//--- tests/tb_fp_cast.sv
// ----------------------------------------------------------
// Testbench of the pipelined float/int conversion unit
// Directed and random requests, in-order scoreboard by tag
// ----------------------------------------------------------
`timescale 1ns/1ps

module tb_fp_cast import cast_pkg::*; ();

  localparam int unsigned TagWidth = 4;

  logic                clk;
  logic                arst_n;
  logic                in_valid;
  logic                in_ready;
  logic [31:0]         operand;
  cast_op_e            op;
  logic                is_unsigned;
  round_mode_e         rnd_mode;
  logic [TagWidth-1:0] tag;
  logic                out_valid;
  logic                out_ready;
  logic [31:0]         result;
  cast_status_t        status;
  logic [TagWidth-1:0] tag_out;

  typedef struct {
    logic [31:0]         result;
    cast_status_t        status;
    logic [TagWidth-1:0] tag;
    string               name;
    int                  accept_cycle;
  } exp_t;

  exp_t        expq[$];     // Expected responses in request order
  string       cur_name;    // Name of the request on the bus
  int          cycles;
  int          limit;
  int          errors;
  int          checks;
  int          rsp_count;
  logic        bp_mode;     // Random out_ready when set

  // Integers zero, +-1, powers of two, ties, INT32 min, UINT32 max
  logic [31:0] i2f_vals [12] = '{32'h0000_0000, 32'h0000_0001, 32'hffff_ffff, 32'h0000_0010,
                                 32'h0080_0000, 32'h0100_0000, 32'h0100_0001, 32'h0100_0003,
                                 32'h4000_0000, 32'h8000_0000, 32'h7fff_ffff, 32'hffff_fff5};
  // Exact values, fractions, ties and subnormals
  logic [31:0] f2i_vals [12] = '{32'h3f80_0000, 32'hc000_0000, 32'h4eff_ffff, 32'h3fc0_0000,
                                 32'h4020_0000, 32'hbfc0_0000, 32'h3f00_0000, 32'hbf00_0000,
                                 32'h3e99_999a, 32'hbf33_3333, 32'h0000_0001, 32'h8040_0000};
  // NaN, inf, overflow both ways, -2^31, negatives for unsigned
  logic [31:0] f2i_specials [10] = '{32'h7fc0_0000, 32'hffc0_0000, 32'h7f80_0000, 32'hff80_0000,
                                     32'h4f00_0000, 32'h4f80_0000, 32'hcf00_0000, 32'hcf32_d05e,
                                     32'h5015_02f9, 32'hbf80_0000};

  `include "tb_fp_cast_ref.svh"

  fp_cast_top #(
    .TagWidth ( TagWidth )
  ) i_fp_cast_top (
    .clk_i         ( clk         ),
    .arst_n_i      ( arst_n      ),
    .in_valid_i    ( in_valid    ),
    .in_ready_o    ( in_ready    ),
    .operand_i     ( operand     ),
    .op_i          ( op          ),
    .is_unsigned_i ( is_unsigned ),
    .rnd_mode_i    ( rnd_mode    ),
    .tag_i         ( tag         ),
    .out_valid_o   ( out_valid   ),
    .out_ready_i   ( out_ready   ),
    .result_o      ( result      ),
    .status_o      ( status      ),
    .tag_o         ( tag_out     )
  );

  initial clk = 1'b0;
  always #20 clk = ~clk;  // 40 ns period

  task automatic check_val(string name, logic [31:0] expected, logic [31:0] actual);
    checks++;
    if (expected !== actual) begin
      errors++;
      $display("[ERROR] %s: expected %h, actual %h", name, expected, actual);
    end
  endtask

  // One request under all four rounding modes
  function automatic void add_modes(string name, logic [31:0] val, cast_op_e o, logic uns);
    vec_t v;
    v.operand = val;
    v.op      = o;
    v.uns     = uns;
    v.name    = name;
    for (int m = 0; m < 4; m++) begin
      v.rm = round_mode_e'(m);
      vecs.push_back(v);
    end
  endfunction

  // Holds the request until the input stage takes it
  task automatic send_req(vec_t v);
    logic acc;
    in_valid    = 1'b1;
    operand     = v.operand;
    op          = v.op;
    is_unsigned = v.uns;
    rnd_mode    = v.rm;
    cur_name    = v.name;
    do begin
      @(negedge clk);
      acc = in_ready;
      @(posedge clk);
      #2;
    end while (!acc);
    tag = tag + 1'b1;
  endtask

  always @(posedge clk) begin
    cycles++;
    if (cycles > limit) begin
      $display("Timeout after %0d cycles with %0d of %0d responses received",
               cycles, rsp_count, vecs.size());
      $display("TB FAILED");
      $finish;
    end
  end

  always @(posedge clk) begin
    #2;
    out_ready = bp_mode ? 1'($urandom) : 1'b1;
  end

  // ----------------------------------------------------------
  // Scoreboard sampled mid cycle where the bus is stable
  // ----------------------------------------------------------
  always @(negedge clk) begin : scoreboard
    vec_t         v;
    exp_t         e;
    logic [31:0]  res;
    cast_status_t st;
    if (arst_n && in_valid && in_ready) begin  // Request taken at next edge
      v.operand = operand;
      v.op      = op;
      v.uns     = is_unsigned;
      v.rm      = rnd_mode;
      ref_cast(v, res, st);
      e.result       = res;
      e.status       = st;
      e.tag          = tag;
      e.name         = cur_name;
      e.accept_cycle = cycles;
      expq.push_back(e);
    end
    if (arst_n && out_valid && out_ready) begin
      if (expq.size() == 0) begin
        errors++;
        $display("Response with tag %h arrived while no request was pending", tag_out);
      end else begin
        e = expq.pop_front();
        if (rsp_count == 0) begin
          check_val("first response latency", 32'd2, 32'(cycles - e.accept_cycle));
        end
        check_val({e.name, " tag"}, 32'(e.tag), 32'(tag_out));
        check_val({e.name, " result"}, e.result, result);
        check_val({e.name, " status"}, {30'd0, e.status}, {30'd0, status});
        rsp_count++;
      end
    end
  end

  initial begin : main
    vec_t v;
    int   bp_start;
    void'($urandom(51246));
    limit       = 100;
    cycles      = 0;
    errors      = 0;
    checks      = 0;
    rsp_count   = 0;
    bp_mode     = 1'b0;
    arst_n      = 1'b0;
    in_valid    = 1'b0;
    operand     = '0;
    op          = F2I;
    is_unsigned = 1'b0;
    rnd_mode    = RNE;
    tag         = '0;
    out_ready   = 1'b1;
    cur_name    = "";

    foreach (i2f_vals[i]) begin
      add_modes("i2f signed", i2f_vals[i], I2F, 1'b0);
      add_modes("i2f unsigned", i2f_vals[i], I2F, 1'b1);
    end
    foreach (f2i_vals[i]) begin
      add_modes("f2i signed", f2i_vals[i], F2I, 1'b0);
      add_modes("f2i unsigned", f2i_vals[i], F2I, 1'b1);
    end
    foreach (f2i_specials[i]) begin
      add_modes("f2i special signed", f2i_specials[i], F2I, 1'b0);
      add_modes("f2i special unsigned", f2i_specials[i], F2I, 1'b1);
    end
    for (int i = 0; i < 8; i++) begin
      add_modes("i2f random", $urandom, I2F, 1'($urandom));
      add_modes("f2i random", {1'($urandom), 8'(110 + $urandom_range(0, 50)), 23'($urandom)},
                F2I, 1'($urandom));
    end
    bp_start = vecs.size();
    for (int i = 0; i < 40; i++) begin  // Back-to-back under random out_ready
      v.operand = $urandom;
      v.op      = cast_op_e'(1'($urandom));
      v.uns     = 1'($urandom);
      v.rm      = round_mode_e'(2'($urandom));
      v.name    = "backpressure";
      vecs.push_back(v);
    end
    limit = 4 * vecs.size() + 100;

    repeat (10) @(posedge clk);
    #2;
    arst_n = 1'b1;
    @(negedge clk);
    check_val("idle out_valid", 32'd0, {31'd0, out_valid});
    check_val("idle in_ready", 32'd1, {31'd0, in_ready});
    @(posedge clk);
    #2;

    foreach (vecs[i]) begin
      if (i == bp_start) bp_mode = 1'b1;
      send_req(vecs[i]);
    end
    in_valid = 1'b0;
    bp_mode  = 1'b0;  // Drain with a ready consumer
    wait (rsp_count == vecs.size());
    repeat (3) @(posedge clk);  // Room for a repeated response to show up

    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

//--- logic/fp_cast_top.sv
// ----------------------------------------------------------
// Pipelined binary32 <-> int32 conversion unit
// Input stage, F2I and I2F paths, rounder, output stage
// ----------------------------------------------------------
`timescale 1ns/1ps

module fp_cast_top import cast_pkg::*; #(
  parameter int unsigned TagWidth = 4
) (
  input  logic                 clk_i,
  input  logic                 arst_n_i,
  // Request side
  input  logic                 in_valid_i,
  output logic                 in_ready_o,
  input  logic [INT_WIDTH-1:0] operand_i,
  input  cast_op_e             op_i,
  input  logic                 is_unsigned_i,
  input  round_mode_e          rnd_mode_i,
  input  logic [TagWidth-1:0]  tag_i,
  // Response side
  output logic                 out_valid_o,
  input  logic                 out_ready_i,
  output logic [INT_WIDTH-1:0] result_o,
  output cast_status_t         status_o,
  output logic [TagWidth-1:0]  tag_o
);

  typedef struct packed {
    cast_req_body_t      body;
    logic [TagWidth-1:0] tag;
  } cast_req_t;

  typedef struct packed {
    cast_rsp_body_t      body;
    logic [TagWidth-1:0] tag;
  } cast_rsp_t;

  cast_req_t    req_d, req_q;
  cast_rsp_t    rsp_d, rsp_q;
  logic         mid_valid;   // Input stage holds an item
  logic         mid_ready;   // Output stage can take it
  align_res_t   f2i_res;
  align_res_t   i2f_res;
  logic [INT_WIDTH-1:0] result_d;
  cast_status_t status_d;

  assign req_d = '{
    body: '{operand: operand_i, op: op_i, is_unsigned: is_unsigned_i, rnd_mode: rnd_mode_i},
    tag:  tag_i
  };

  // ----------------------------------------------------------
  // Input stage
  // ----------------------------------------------------------
  cast_pipe_stage #(
    .payload_t ( cast_req_t )
  ) i_in_stage (
    .clk_i    ( clk_i      ),
    .arst_n_i ( arst_n_i   ),
    .valid_i  ( in_valid_i ),
    .ready_o  ( in_ready_o ),
    .data_i   ( req_d      ),
    .valid_o  ( mid_valid  ),
    .ready_i  ( mid_ready  ),
    .data_o   ( req_q      )
  );

  // Both paths look at every operand, the rounder picks one
  f2i_align i_f2i_align (
    .operand_i     ( req_q.body.operand     ),
    .is_unsigned_i ( req_q.body.is_unsigned ),
    .align_o       ( f2i_res                )
  );

  i2f_normalize i_i2f_normalize (
    .operand_i     ( req_q.body.operand     ),
    .is_unsigned_i ( req_q.body.is_unsigned ),
    .align_o       ( i2f_res                )
  );

  cast_round i_cast_round (
    .f2i_i         ( f2i_res                ),
    .i2f_i         ( i2f_res                ),
    .op_i          ( req_q.body.op          ),
    .is_unsigned_i ( req_q.body.is_unsigned ),
    .rnd_mode_i    ( req_q.body.rnd_mode    ),
    .result_o      ( result_d               ),
    .status_o      ( status_d               )
  );

  assign rsp_d = '{body: '{result: result_d, status: status_d}, tag: req_q.tag};

  // ----------------------------------------------------------
  // Output stage
  // ----------------------------------------------------------
  cast_pipe_stage #(
    .payload_t ( cast_rsp_t )
  ) i_out_stage (
    .clk_i    ( clk_i       ),
    .arst_n_i ( arst_n_i    ),
    .valid_i  ( mid_valid   ),
    .ready_o  ( mid_ready   ),
    .data_i   ( rsp_d       ),
    .valid_o  ( out_valid_o ),
    .ready_i  ( out_ready_i ),
    .data_o   ( rsp_q       )
  );

  assign result_o = rsp_q.body.result;
  assign status_o = rsp_q.body.status;
  assign tag_o    = rsp_q.tag;

endmodule

//--- logic/cast_round.sv
// ----------------------------------------------------------
// Rounding and assembly for both conversion directions
// Applies the rounding mode, saturates F2I results and
// builds the result with NV and NX flags
// ----------------------------------------------------------
`timescale 1ns/1ps

module cast_round import cast_pkg::*; (
  input  align_res_t           f2i_i,
  input  align_res_t           i2f_i,
  input  cast_op_e             op_i,
  input  logic                 is_unsigned_i,
  input  round_mode_e          rnd_mode_i,
  output logic [INT_WIDTH-1:0] result_o,
  output cast_status_t         status_o
);

  align_res_t           sel;          // Path picked by operation
  logic                 round_up;
  logic                 inexact;

  logic [INT_WIDTH-1:0] fp_sum;       // Exponent and mantissa after increment
  logic [INT_WIDTH-1:0] fp_res;

  logic [INT_WIDTH:0]   int_sum;      // Rounded magnitude with carry
  logic [INT_WIDTH-1:0] int_res;
  logic [INT_WIDTH-1:0] int_sat;
  logic                 int_ovf;
  logic                 neg_unsigned;
  logic                 int_special;

  assign sel     = (op_i == I2F) ? i2f_i : f2i_i;
  assign inexact = sel.rnd | sel.sticky;

  // ----------------------------------------------------------
  // Rounding decision
  // ----------------------------------------------------------
  always_comb begin : round_decision
    case (rnd_mode_i)
      RNE:     round_up = sel.rnd & (sel.sticky | sel.mag[0]);  // Ties to even LSB
      RTZ:     round_up = 1'b0;
      RDN:     round_up = inexact & sel.sign;
      RUP:     round_up = inexact & ~sel.sign;
      default: round_up = 1'b0;
    endcase
  end

  // ----------------------------------------------------------
  // I2F assembly
  // ----------------------------------------------------------
  // Mantissa carry walks into the exponent, no overflow from int32
  assign fp_sum = {i2f_i.exp, i2f_i.mag[FP_MAN_BITS-1:0]} + INT_WIDTH'(round_up);
  assign fp_res = {i2f_i.sign, fp_sum[INT_WIDTH-2:0]};

  // ----------------------------------------------------------
  // F2I assembly
  // ----------------------------------------------------------
  assign int_sum = {1'b0, f2i_i.mag} + (INT_WIDTH+1)'(round_up);
  assign int_res = f2i_i.sign ? -int_sum[INT_WIDTH-1:0] : int_sum[INT_WIDTH-1:0];

  // Range check after rounding
  always_comb begin : overflow_check
    if (is_unsigned_i) begin
      int_ovf = ~f2i_i.sign & int_sum[INT_WIDTH];
    end else if (f2i_i.sign) begin
      // Magnitude up to 2^31 is fine when negative
      int_ovf = int_sum[INT_WIDTH] | (int_sum[INT_WIDTH-1] & |int_sum[INT_WIDTH-2:0]);
    end else begin
      int_ovf = int_sum[INT_WIDTH] | int_sum[INT_WIDTH-1];
    end
  end

  // Negative value that did not round to zero has no unsigned form
  assign neg_unsigned = is_unsigned_i & f2i_i.sign & (int_sum != '0);

  always_comb begin : saturate
    if (is_unsigned_i) begin
      int_sat = f2i_i.sign ? '0 : UINT32_MAX;
    end else begin
      int_sat = f2i_i.sign ? INT32_MIN : INT32_MAX;
    end
  end

  assign int_special = f2i_i.special | int_ovf | neg_unsigned;

  // ----------------------------------------------------------
  // Result and flags
  // ----------------------------------------------------------
  always_comb begin : select_result
    if (op_i == I2F) begin
      result_o    = i2f_i.special ? i2f_i.special_val : fp_res;
      status_o.nv = 1'b0;                          // Every int32 is representable
      status_o.nx = ~i2f_i.special & inexact;
    end else begin
      if (f2i_i.special) begin
        result_o = f2i_i.special_val;              // NaN, inf, out of range
      end else if (int_special) begin
        result_o = int_sat;                        // Overflow caused by rounding
      end else begin
        result_o = int_res;
      end
      status_o.nv = int_special;                   // All F2I specials are invalid
      status_o.nx = ~int_special & inexact;
    end
  end

endmodule

//--- logic/i2f_normalize.sv
// ----------------------------------------------------------
// I2F front path
// Takes the integer magnitude, counts leading zeros and
// normalizes it into a binary32 mantissa and exponent
// ----------------------------------------------------------
`timescale 1ns/1ps

module i2f_normalize import cast_pkg::*; (
  input  logic [INT_WIDTH-1:0] operand_i,
  input  logic                 is_unsigned_i,
  output align_res_t           align_o
);

  // Bit of the normalized word just below the kept mantissa
  localparam int unsigned RND_POS = INT_WIDTH - FP_MAN_BITS - 2;

  logic                 neg;
  logic [INT_WIDTH-1:0] mag_abs;     // Magnitude of the input
  logic [5:0]           lz_cnt;      // Leading zeros
  logic [INT_WIDTH-1:0] norm;        // MSB is the hidden bit
  logic [8:0]           biased_exp;
  logic                 is_zero;

  // Only signed inputs can be negative
  assign neg     = ~is_unsigned_i & operand_i[INT_WIDTH-1];
  assign mag_abs = neg ? -operand_i : operand_i;  // INT32_MIN stays 2^31
  assign is_zero = (mag_abs == '0);

  // ----------------------------------------------------------
  // Leading zero count
  // ----------------------------------------------------------
  always_comb begin : lzc
    lz_cnt = '0;
    // Highest set bit wins since it is visited last
    for (int i = 0; i < INT_WIDTH; i++) begin
      if (mag_abs[i]) begin
        lz_cnt = 6'(INT_WIDTH - 1 - i);
      end
    end
  end

  assign norm = mag_abs << lz_cnt;

  // Value is 1.f * 2^(31 - lz), rebias for binary32
  assign biased_exp = 9'(FP_BIAS + INT_WIDTH - 1) - {3'b000, lz_cnt};

  assign align_o = '{
    sign:        neg,
    mag:         {{(MAN_WIDTH-FP_MAN_BITS){1'b0}}, norm[INT_WIDTH-2 -: FP_MAN_BITS]},
    rnd:         norm[RND_POS],
    sticky:      |norm[RND_POS-1:0],
    exp:         biased_exp,
    special:     is_zero,          // Zero has no leading one
    special_val: '0                // +0
  };

endmodule

//--- logic/f2i_align.sv
// ----------------------------------------------------------
// F2I front path
// Classifies the binary32 operand and right-shifts the mantissa
// to integer position with round and sticky bits
// ----------------------------------------------------------
`timescale 1ns/1ps

module f2i_align import cast_pkg::*; (
  input  logic [INT_WIDTH-1:0] operand_i,
  input  logic                 is_unsigned_i,
  output align_res_t           align_o
);

  localparam int unsigned PAD_BITS = 2 * MAN_WIDTH - FP_MAN_BITS - 1;  // Zeros below mantissa

  logic                   sign;
  logic [FP_EXP_BITS-1:0] exp_field;
  logic [FP_MAN_BITS-1:0] man_field;
  logic [FP_EXP_BITS-1:0] exp_eff;     // Subnormals use exponent 1
  logic [FP_MAN_BITS:0]   mant;        // With hidden bit
  logic                   is_nan;
  logic                   is_inf;
  logic                   is_int_min;
  logic                   exp_ovf;
  logic signed [9:0]      exp_unb;     // Unbiased exponent
  logic signed [9:0]      exp_limit;   // First exponent out of range
  logic signed [9:0]      shamt_full;
  logic [2*MAN_WIDTH-1:0] shifted;     // Integer part in upper half
  logic [MAN_WIDTH-1:0]   int_part;
  logic                   rnd_bit;
  logic                   sticky_bit;
  logic [INT_WIDTH-1:0]   special_val;

  // ----------------------------------------------------------
  // Unpack and classify
  // ----------------------------------------------------------
  assign sign      = operand_i[INT_WIDTH-1];
  assign exp_field = operand_i[FP_MAN_BITS +: FP_EXP_BITS];
  assign man_field = operand_i[FP_MAN_BITS-1:0];

  assign is_nan = (exp_field == '1) && (man_field != '0);
  assign is_inf = (exp_field == '1) && (man_field == '0);

  assign exp_eff = (exp_field == '0) ? FP_EXP_BITS'(1) : exp_field;
  assign mant    = {(exp_field != '0), man_field};  // Hidden bit only for normals
  assign exp_unb = $signed({2'b00, exp_eff}) - $signed(10'(FP_BIAS));

  // Unsigned range reaches one exponent further
  assign exp_limit = $signed(10'(INT_WIDTH - 1)) + $signed({9'd0, is_unsigned_i});

  // Exactly -2^31 still fits a signed result
  assign is_int_min = ~is_unsigned_i & sign & (man_field == '0) &
                      (exp_unb == $signed(10'(INT_WIDTH - 1)));

  assign exp_ovf = (exp_unb >= exp_limit) & ~is_int_min;  // Also true for NaN and inf

  // ----------------------------------------------------------
  // Alignment
  // ----------------------------------------------------------
  // Mantissa MSB sits at weight 2^31 when shift is zero
  assign shamt_full = $signed(10'(INT_WIDTH - 1)) - exp_unb;
  assign shifted    = {mant, {PAD_BITS{1'b0}}} >> shamt_full[5:0];

  always_comb begin : align
    if (exp_unb < -10'sd1) begin
      // Below one half, every bit ends in the sticky
      int_part   = '0;
      rnd_bit    = 1'b0;
      sticky_bit = |mant;
    end else begin
      int_part   = shifted[2*MAN_WIDTH-1 -: MAN_WIDTH];
      rnd_bit    = shifted[MAN_WIDTH-1];
      sticky_bit = |shifted[MAN_WIDTH-2:0];
    end
  end

  // Saturated value, NaN goes to positive max
  always_comb begin : saturate
    if (is_nan || !sign) begin
      special_val = is_unsigned_i ? UINT32_MAX : INT32_MAX;
    end else begin
      special_val = is_unsigned_i ? '0 : INT32_MIN;  // Negative overflow
    end
  end

  assign align_o = '{
    sign:        sign,
    mag:         int_part,
    rnd:         rnd_bit,
    sticky:      sticky_bit,
    exp:         '0,               // Not needed on this path
    special:     is_nan | is_inf | exp_ovf,
    special_val: special_val
  };

endmodule

//--- logic/cast_pipe_stage.sv
// ----------------------------------------------------------
// Valid/ready register stage, any packed payload
// Ready when empty or downstream ready, so bubbles are popped
// ----------------------------------------------------------
`timescale 1ns/1ps

module cast_pipe_stage #(
  parameter type payload_t = logic
) (
  input  logic     clk_i,
  input  logic     arst_n_i,
  input  logic     valid_i,
  output logic     ready_o,
  input  payload_t data_i,
  output logic     valid_o,
  input  logic     ready_i,
  output payload_t data_o
);

  logic     valid_q;
  payload_t data_q;

  // Advance when next stage takes our item or we only hold a bubble
  assign ready_o = ready_i | ~valid_q;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      valid_q <= 1'b0;
    end else if (ready_o) begin
      valid_q <= valid_i;  // Follows upstream valid at each load
    end
  end

  // Payload register, enabled only for real items
  always_ff @(posedge clk_i) begin
    if (ready_o && valid_i) begin
      data_q <= data_i;
    end
  end

  assign valid_o = valid_q;
  assign data_o  = data_q;

endmodule

//--- logic/cast_pkg.sv
// ----------------------------------------------------------
// Shared definitions of the float/int conversion unit
// Formats, operation and rounding enums, datapath structs
// ----------------------------------------------------------

package cast_pkg;

  // ----------------------------------------------------------
  // Formats
  // ----------------------------------------------------------
  localparam int unsigned FP_EXP_BITS = 8;    // binary32 exponent field
  localparam int unsigned FP_MAN_BITS = 23;   // binary32 mantissa field
  localparam int unsigned FP_BIAS     = 127;
  localparam int unsigned INT_WIDTH   = 32;   // int32 and uint32

  // Internal mantissa holds a full integer or the mantissa with hidden bit
  localparam int unsigned MAN_WIDTH =
      (INT_WIDTH > FP_MAN_BITS + 1) ? INT_WIDTH : FP_MAN_BITS + 1;

  // Saturation values for F2I
  localparam logic [INT_WIDTH-1:0] INT32_MAX  = 32'h7fff_ffff;
  localparam logic [INT_WIDTH-1:0] INT32_MIN  = 32'h8000_0000;
  localparam logic [INT_WIDTH-1:0] UINT32_MAX = 32'hffff_ffff;

  // ----------------------------------------------------------
  // Operation and rounding mode
  // ----------------------------------------------------------
  typedef enum logic {
    F2I = 1'b0,  // float to int
    I2F = 1'b1   // int to float
  } cast_op_e;

  typedef enum logic [1:0] {
    RNE = 2'b00,  // To nearest, ties to even
    RTZ = 2'b01,  // Toward zero
    RDN = 2'b10,  // Toward minus infinity
    RUP = 2'b11   // Toward plus infinity
  } round_mode_e;

  // Exception flags
  typedef struct packed {
    logic nv;  // Invalid
    logic nx;  // Inexact
  } cast_status_t;

  // Request fields without the tag, the tag is added at the top level
  typedef struct packed {
    logic [INT_WIDTH-1:0] operand;
    cast_op_e             op;
    logic                 is_unsigned;
    round_mode_e          rnd_mode;
  } cast_req_body_t;

  // Output of each front path toward the rounder
  typedef struct packed {
    logic                 sign;
    logic [MAN_WIDTH-1:0] mag;          // Integer part, or mantissa in low bits for I2F
    logic                 rnd;          // First dropped bit
    logic                 sticky;       // OR of all lower dropped bits
    logic [8:0]           exp;          // Biased exponent, I2F only
    logic                 special;      // Result bypasses rounding
    logic [INT_WIDTH-1:0] special_val;
  } align_res_t;

  // Response fields without the tag
  typedef struct packed {
    logic [INT_WIDTH-1:0] result;
    cast_status_t         status;
  } cast_rsp_body_t;

endpackage
